//--- ldbal_settings.svh
// single-beat reads only; every depth here must be a power of two
`ifndef LDBAL_SETTINGS_SVH
`define LDBAL_SETTINGS_SVH

// requester ports and DDR channels
`define LDBAL_NUM_PORTS    4
`define LDBAL_NUM_CHANS    4

// bus widths
`define LDBAL_ADDR_W       48
`define LDBAL_DATA_W       64

// reorder buffer holds 2**SEQ_W slots per port
`define LDBAL_SEQ_W        3
`define LDBAL_REQ_DEPTH    8
// in-flight limit per channel, same depth for its return buffer
`define LDBAL_CHAN_MAX_OUT 4
`define LDBAL_SERVE_W      16

`endif

//--- ldbal_req_pkg.sv
// request-side types; index widths follow the port and channel counts in the settings header
`include "ldbal_settings.svh"

package ldbal_req_pkg;

    // read address as presented by a requester
    typedef logic [`LDBAL_ADDR_W-1:0] addr_t;

    // per-port sequence tag, wraps at 2**SEQ_W
    typedef logic [`LDBAL_SEQ_W-1:0] seq_t;

    typedef logic [$clog2(`LDBAL_NUM_PORTS)-1:0] port_id_t;
    typedef logic [$clog2(`LDBAL_NUM_CHANS)-1:0] chan_id_t;

    // queued request, address above tag
    typedef struct packed {
        addr_t addr;
        seq_t  seq;
    } req_entry_t;

endpackage

//--- ldbal_ret_pkg.sv
// return-side types; a tag names the requester port and its sequence slot
`include "ldbal_settings.svh"

package ldbal_ret_pkg;

    // one returned data beat
    typedef logic [`LDBAL_DATA_W-1:0] data_t;

    // in-flight tag, carried from issue until data comes back
    typedef struct packed {
        ldbal_req_pkg::port_id_t port;
        ldbal_req_pkg::seq_t     seq;
    } tag_t;

    // returned read waiting for the reorder buffers
    typedef struct packed {
        tag_t  tag;
        data_t data;
    } ret_entry_t;

endpackage

//--- sync_fifo.sv
// DEPTH must be a power of two; push when full and pop when empty are dropped
`timescale 1ns/1ps

module sync_fifo #(
    parameter int WIDTH = 8,
    parameter int DEPTH = 4
) (
    input  logic             clk,
    input  logic             rstn,
    input  logic             push,
    input  logic [WIDTH-1:0] wdata,
    input  logic             pop,
    output logic [WIDTH-1:0] rdata,
    output logic             empty,
    output logic             full
);
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    logic [WIDTH-1:0] mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W:0]   count;
    logic             do_push;
    logic             do_pop;

    assign do_push = push && !full;
    assign do_pop  = pop && !empty;
    assign empty   = (count == '0);
    assign full    = (count == (PTR_W+1)'(DEPTH));
    // head of queue, no output register
    assign rdata   = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (!rstn) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            count <= count + (PTR_W+1)'(do_push) - (PTR_W+1)'(do_pop);
        end
    end

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= wdata;
        end
    end

endmodule

//--- request_queue.sv
// one requester port; at most 2**SEQ_W reads outstanding so tags never reuse a live slot
`timescale 1ns/1ps
`include "ldbal_settings.svh"

module request_queue (
    input  logic                      clk,
    input  logic                      rstn,
    input  ldbal_req_pkg::addr_t      araddr,
    input  logic                      arvalid,
    output logic                      arready,
    input  logic                      pop,
    input  logic                      retire,
    output ldbal_req_pkg::req_entry_t head,
    output logic                      nonempty
);
    localparam int MAX_OUT = 1 << `LDBAL_SEQ_W;

    ldbal_req_pkg::seq_t       seq_cnt;
    logic [`LDBAL_SEQ_W:0]     credits;
    ldbal_req_pkg::req_entry_t entry;
    logic                      accept;
    logic                      q_full;
    logic                      q_empty;

    assign arready  = !q_full && (credits < (`LDBAL_SEQ_W+1)'(MAX_OUT));
    assign accept   = arvalid && arready;
    assign nonempty = !q_empty;

    always_comb begin
        entry.addr = araddr;
        entry.seq  = seq_cnt;
    end

    // credit taken on accept, handed back when the reorder buffer retires
    always_ff @(posedge clk) begin
        if (!rstn) begin
            seq_cnt <= '0;
            credits <= '0;
        end else begin
            if (accept) begin
                seq_cnt <= seq_cnt + 1'b1;
            end
            credits <= credits + (`LDBAL_SEQ_W+1)'(accept) - (`LDBAL_SEQ_W+1)'(retire);
        end
    end

    sync_fifo #(
        .WIDTH ($bits(ldbal_req_pkg::req_entry_t)),
        .DEPTH (`LDBAL_REQ_DEPTH)
    ) u_fifo (
        .clk   (clk),
        .rstn  (rstn),
        .push  (accept),
        .wdata (entry),
        .pop   (pop),
        .rdata (head),
        .empty (q_empty),
        .full  (q_full)
    );

endmodule

//--- channel_tracker.sv
// one DDR channel; assumes the channel answers reads in issue order, one beat each
`timescale 1ns/1ps
`include "ldbal_settings.svh"

module channel_tracker (
    input  logic                      clk,
    input  logic                      rstn,
    input  logic                      push,
    input  ldbal_ret_pkg::tag_t       push_tag,
    input  ldbal_ret_pkg::data_t      rdata,
    input  logic                      rvalid,
    output logic                      rready,
    input  logic                      pop,
    output logic                      idle,
    output logic                      full,
    output ldbal_ret_pkg::ret_entry_t post,
    output logic                      post_valid
);
    ldbal_ret_pkg::tag_t       head_tag;
    ldbal_ret_pkg::ret_entry_t joined;
    logic                      data_hs;
    logic                      tag_empty;
    logic                      ret_empty;
    logic                      ret_full;

    assign rready     = !ret_full;
    assign data_hs    = rvalid && rready;
    assign post_valid = !ret_empty;
    // nothing issued and nothing waiting to be returned
    assign idle       = tag_empty && ret_empty;

    always_comb begin
        joined.tag  = head_tag;
        joined.data = rdata;
    end

    // oldest issued tag pairs with each arriving beat
    sync_fifo #(
        .WIDTH ($bits(ldbal_ret_pkg::tag_t)),
        .DEPTH (`LDBAL_CHAN_MAX_OUT)
    ) u_tag_q (
        .clk   (clk),
        .rstn  (rstn),
        .push  (push),
        .wdata (push_tag),
        .pop   (data_hs),
        .rdata (head_tag),
        .empty (tag_empty),
        .full  (full)
    );

    sync_fifo #(
        .WIDTH ($bits(ldbal_ret_pkg::ret_entry_t)),
        .DEPTH (`LDBAL_CHAN_MAX_OUT)
    ) u_ret_q (
        .clk   (clk),
        .rstn  (rstn),
        .push  (data_hs),
        .wdata (joined),
        .pop   (pop),
        .rdata (post),
        .empty (ret_empty),
        .full  (ret_full)
    );

endmodule

//--- issue_control.sv
// selection is combinational; channel arvalid is only raised on a channel whose arready is high
`timescale 1ns/1ps
`include "ldbal_settings.svh"

module issue_control (
    input  logic                                             clk,
    input  logic                                             rstn,
    input  ldbal_req_pkg::req_entry_t [`LDBAL_NUM_PORTS-1:0] q_head,
    input  logic [`LDBAL_NUM_PORTS-1:0]                      q_nonempty,
    output logic [`LDBAL_NUM_PORTS-1:0]                      q_pop,
    input  logic [`LDBAL_NUM_CHANS-1:0]                      chan_idle,
    input  logic [`LDBAL_NUM_CHANS-1:0]                      chan_full,
    input  logic [`LDBAL_NUM_CHANS-1:0]                      chan_arready,
    output logic [`LDBAL_NUM_CHANS-1:0]                      chan_arvalid,
    output ldbal_req_pkg::addr_t [`LDBAL_NUM_CHANS-1:0]      chan_araddr,
    output logic [`LDBAL_NUM_CHANS-1:0]                      issue_push,
    output ldbal_ret_pkg::tag_t                              issue_tag,
    input  ldbal_ret_pkg::ret_entry_t [`LDBAL_NUM_CHANS-1:0] post,
    input  logic [`LDBAL_NUM_CHANS-1:0]                      post_valid,
    input  logic [`LDBAL_NUM_CHANS-1:0]                      post_full,
    output logic [`LDBAL_NUM_CHANS-1:0]                      post_pop,
    output logic                                             wb_valid,
    output ldbal_ret_pkg::ret_entry_t                        wb_entry
);
    localparam int NP = `LDBAL_NUM_PORTS;
    localparam int NC = `LDBAL_NUM_CHANS;

    typedef enum logic {
        st_quiet,
        st_run
    } state_t;

    state_t                   state;
    logic [`LDBAL_SERVE_W-1:0] serve_cnt [NP];
    ldbal_req_pkg::port_id_t  port_sel;
    ldbal_req_pkg::chan_id_t  chan_sel;
    ldbal_req_pkg::chan_id_t  ret_sel;
    logic                     port_found;
    logic                     chan_found;
    logic                     ret_found;
    logic                     issue_ok;
    logic                     fire;

    // one quiet cycle after reset before any issue
    always_ff @(posedge clk) begin
        if (!rstn) begin
            state <= st_quiet;
        end else begin
            state <= st_run;
        end
    end

    // least-served non-empty port, strict compare keeps the lowest index on a tie
    always_comb begin
        port_found = 1'b0;
        port_sel   = '0;
        for (int p = 0; p < NP; p++) begin
            if (q_nonempty[p] && (!port_found || serve_cnt[p] < serve_cnt[port_sel])) begin
                port_found = 1'b1;
                port_sel   = ldbal_req_pkg::port_id_t'(p);
            end
        end
    end

    // first idle channel, then first one below its in-flight limit
    always_comb begin
        chan_found = 1'b0;
        chan_sel   = '0;
        for (int c = 0; c < NC; c++) begin
            if (!chan_found && chan_arready[c] && chan_idle[c]) begin
                chan_found = 1'b1;
                chan_sel   = ldbal_req_pkg::chan_id_t'(c);
            end
        end
        for (int c = 0; c < NC; c++) begin
            if (!chan_found && chan_arready[c] && !chan_full[c]) begin
                chan_found = 1'b1;
                chan_sel   = ldbal_req_pkg::chan_id_t'(c);
            end
        end
    end

    // a full return buffer goes first, otherwise the lowest non-empty one
    always_comb begin
        ret_found = 1'b0;
        ret_sel   = '0;
        for (int c = 0; c < NC; c++) begin
            if (!ret_found && post_full[c]) begin
                ret_found = 1'b1;
                ret_sel   = ldbal_req_pkg::chan_id_t'(c);
            end
        end
        for (int c = 0; c < NC; c++) begin
            if (!ret_found && post_valid[c]) begin
                ret_found = 1'b1;
                ret_sel   = ldbal_req_pkg::chan_id_t'(c);
            end
        end
    end

    assign issue_ok      = (state == st_run) && port_found && chan_found;
    assign fire          = issue_ok && chan_arready[chan_sel];
    assign issue_tag.port = port_sel;
    assign issue_tag.seq  = q_head[port_sel].seq;
    assign wb_valid      = ret_found;
    assign wb_entry      = post[ret_sel];

    always_comb begin
        for (int c = 0; c < NC; c++) begin
            chan_arvalid[c] = issue_ok && (chan_sel == ldbal_req_pkg::chan_id_t'(c));
            chan_araddr[c]  = q_head[port_sel].addr;
            issue_push[c]   = fire && (chan_sel == ldbal_req_pkg::chan_id_t'(c));
            post_pop[c]     = ret_found && (ret_sel == ldbal_req_pkg::chan_id_t'(c));
        end
        for (int p = 0; p < NP; p++) begin
            q_pop[p] = fire && (port_sel == ldbal_req_pkg::port_id_t'(p));
        end
    end

    // only a completed channel handshake counts as a serve
    always_ff @(posedge clk) begin
        if (!rstn) begin
            for (int p = 0; p < NP; p++) begin
                serve_cnt[p] <= '0;
            end
        end else if (fire) begin
            serve_cnt[port_sel] <= serve_cnt[port_sel] + 1'b1;
        end
    end

endmodule

//--- reorder_buffer.sv
// one port; relies on the request credit limit so a slot is never rewritten before retire
`timescale 1ns/1ps
`include "ldbal_settings.svh"

module reorder_buffer (
    input  logic                      clk,
    input  logic                      rstn,
    input  logic                      wr,
    input  ldbal_ret_pkg::ret_entry_t wr_entry,
    output ldbal_ret_pkg::data_t      rdata,
    output logic                      rvalid,
    input  logic                      rready,
    output logic                      retire
);
    localparam int SLOTS = 1 << `LDBAL_SEQ_W;

    ldbal_ret_pkg::data_t slot_data [SLOTS];
    logic [SLOTS-1:0]     slot_valid;
    ldbal_req_pkg::seq_t  wb_ptr;

    // head slot drives the port until accepted
    assign rvalid = slot_valid[wb_ptr];
    assign rdata  = slot_data[wb_ptr];
    assign retire = rvalid && rready;

    always_ff @(posedge clk) begin
        if (wr) begin
            slot_data[wr_entry.tag.seq] <= wr_entry.data;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            slot_valid <= '0;
            wb_ptr     <= '0;
        end else begin
            if (retire) begin
                slot_valid[wb_ptr] <= 1'b0;
                wb_ptr             <= wb_ptr + 1'b1;
            end
            // never the retiring slot, credits keep the tag space apart
            if (wr) begin
                slot_valid[wr_entry.tag.seq] <= 1'b1;
            end
        end
    end

endmodule

//--- load_balancer.sv
// four requester ports to four DDR channels; channel arready must not depend on arvalid
`timescale 1ns/1ps
`include "ldbal_settings.svh"

module load_balancer (
    input  logic                                         clk,
    input  logic                                         rstn,
    input  ldbal_req_pkg::addr_t [`LDBAL_NUM_PORTS-1:0]  port_araddr,
    input  logic [`LDBAL_NUM_PORTS-1:0]                  port_arvalid,
    output logic [`LDBAL_NUM_PORTS-1:0]                  port_arready,
    output ldbal_ret_pkg::data_t [`LDBAL_NUM_PORTS-1:0]  port_rdata,
    output logic [`LDBAL_NUM_PORTS-1:0]                  port_rvalid,
    input  logic [`LDBAL_NUM_PORTS-1:0]                  port_rready,
    output ldbal_req_pkg::addr_t [`LDBAL_NUM_CHANS-1:0]  chan_araddr,
    output logic [`LDBAL_NUM_CHANS-1:0]                  chan_arvalid,
    input  logic [`LDBAL_NUM_CHANS-1:0]                  chan_arready,
    input  ldbal_ret_pkg::data_t [`LDBAL_NUM_CHANS-1:0]  chan_rdata,
    input  logic [`LDBAL_NUM_CHANS-1:0]                  chan_rvalid,
    output logic [`LDBAL_NUM_CHANS-1:0]                  chan_rready
);
    localparam int NP = `LDBAL_NUM_PORTS;
    localparam int NC = `LDBAL_NUM_CHANS;

    ldbal_req_pkg::req_entry_t [NP-1:0] q_head;
    logic [NP-1:0]                      q_nonempty;
    logic [NP-1:0]                      q_pop;
    logic [NP-1:0]                      retire;
    logic [NC-1:0]                      chan_idle;
    logic [NC-1:0]                      chan_full;
    logic [NC-1:0]                      issue_push;
    ldbal_ret_pkg::tag_t                issue_tag;
    ldbal_ret_pkg::ret_entry_t [NC-1:0] post;
    logic [NC-1:0]                      post_valid;
    logic [NC-1:0]                      post_pop;
    logic                               wb_valid;
    ldbal_ret_pkg::ret_entry_t          wb_entry;

    for (genvar p = 0; p < NP; p++) begin : g_port
        request_queue u_req_q (
            .clk      (clk),
            .rstn     (rstn),
            .araddr   (port_araddr[p]),
            .arvalid  (port_arvalid[p]),
            .arready  (port_arready[p]),
            .pop      (q_pop[p]),
            .retire   (retire[p]),
            .head     (q_head[p]),
            .nonempty (q_nonempty[p])
        );

        // broadcast return, strobe only for the owning port
        reorder_buffer u_rob (
            .clk      (clk),
            .rstn     (rstn),
            .wr       (wb_valid && (wb_entry.tag.port == ldbal_req_pkg::port_id_t'(p))),
            .wr_entry (wb_entry),
            .rdata    (port_rdata[p]),
            .rvalid   (port_rvalid[p]),
            .rready   (port_rready[p]),
            .retire   (retire[p])
        );
    end

    for (genvar c = 0; c < NC; c++) begin : g_chan
        channel_tracker u_trk (
            .clk        (clk),
            .rstn       (rstn),
            .push       (issue_push[c]),
            .push_tag   (issue_tag),
            .rdata      (chan_rdata[c]),
            .rvalid     (chan_rvalid[c]),
            .rready     (chan_rready[c]),
            .pop        (post_pop[c]),
            .idle       (chan_idle[c]),
            .full       (chan_full[c]),
            .post       (post[c]),
            .post_valid (post_valid[c])
        );
    end

    // return buffer full shows up as a dropped channel rready
    issue_control u_ctrl (
        .clk          (clk),
        .rstn         (rstn),
        .q_head       (q_head),
        .q_nonempty   (q_nonempty),
        .q_pop        (q_pop),
        .chan_idle    (chan_idle),
        .chan_full    (chan_full),
        .chan_arready (chan_arready),
        .chan_arvalid (chan_arvalid),
        .chan_araddr  (chan_araddr),
        .issue_push   (issue_push),
        .issue_tag    (issue_tag),
        .post         (post),
        .post_valid   (post_valid),
        .post_full    (~chan_rready),
        .post_pop     (post_pop),
        .wb_valid     (wb_valid),
        .wb_entry     (wb_entry)
    );

endmodule

//--- tb_ddr_channel.sv
// simulation model only; answers reads in order, one beat each, LATENCY cycles after the request
`timescale 1ns/1ps

module tb_ddr_channel #(
    parameter int LATENCY = 2
) (
    input  logic                 clk,
    input  logic                 rstn,
    input  logic                 stall,
    input  ldbal_req_pkg::addr_t araddr,
    input  logic                 arvalid,
    output logic                 arready,
    output ldbal_ret_pkg::data_t rdata,
    output logic                 rvalid,
    input  logic                 rready
);
    ldbal_ret_pkg::data_t pend_data [$];
    int                   pend_due [$];
    int                   cyc;

    assign arready = !stall;

    // idle return bus before the first clock edge
    initial begin
        rvalid <= 1'b0;
        rdata  <= '0;
    end

    always @(posedge clk) begin
        if (!rstn) begin
            cyc = 0;
            pend_data.delete();
            pend_due.delete();
            rvalid <= 1'b0;
            rdata  <= '0;
        end else begin
            cyc = cyc + 1;
            if (arvalid && arready) begin
                // address zero-extended, top bytes flipped
                pend_data.push_back(ldbal_ret_pkg::data_t'(araddr) ^ 64'h5a5a_0000_0000_0000);
                pend_due.push_back(cyc + LATENCY);
            end
            // next beat only once the current one is taken
            if (!rvalid || rready) begin
                if (pend_data.size() > 0 && pend_due[0] <= cyc) begin
                    rvalid <= 1'b1;
                    rdata  <= pend_data.pop_front();
                    pend_due.delete(0);
                end else begin
                    rvalid <= 1'b0;
                end
            end
        end
    end

endmodule

//--- tb_load_balancer.sv
// directed tests of the load balancer; the run stops at the first error or after 4000 cycles
`timescale 1ns/1ps
`include "ldbal_settings.svh"

module tb_load_balancer;

    localparam int num_ports = `LDBAL_NUM_PORTS;
    localparam int num_chans = `LDBAL_NUM_CHANS;
    // roughly 400 cycles of traffic across the five tests with tenfold margin
    localparam int timeout_cycles = 4000;
    localparam logic [31:0] seed = 32'h6749142a;

    logic clk = 1'b0;
    logic rstn;

    ldbal_req_pkg::addr_t [num_ports-1:0] port_araddr;
    logic [num_ports-1:0]                 port_arvalid;
    wire  [num_ports-1:0]                 port_arready;
    wire  ldbal_ret_pkg::data_t [num_ports-1:0] port_rdata;
    wire  [num_ports-1:0]                 port_rvalid;
    logic [num_ports-1:0]                 port_rready;
    wire  ldbal_req_pkg::addr_t [num_chans-1:0] chan_araddr;
    wire  [num_chans-1:0]                 chan_arvalid;
    wire  [num_chans-1:0]                 chan_arready;
    wire  ldbal_ret_pkg::data_t [num_chans-1:0] chan_rdata;
    wire  [num_chans-1:0]                 chan_rvalid;
    wire  [num_chans-1:0]                 chan_rready;
    logic [num_chans-1:0]                 chan_stall;

    // reference model of requested addresses per port in order
    ldbal_req_pkg::addr_t exp_mem [num_ports][256];
    int                   exp_wr [num_ports];
    int                   exp_rd [num_ports];
    ldbal_req_pkg::addr_t addr_plan [num_ports][16];

    logic [31:0]          rnd_state = seed;
    logic [31:0]          stall_state = seed;
    logic [num_ports-1:0] hold_rready;
    logic                 rand_stall;
    logic [num_ports-1:0] next_ready;

    logic [num_ports-1:0] last_valid;
    logic [num_ports-1:0] last_ready;
    ldbal_ret_pkg::data_t last_data [num_ports];

    ldbal_req_pkg::addr_t issue_log [64];
    int                   log_len;
    logic                 log_en;
    int                   chan_hs_cnt [num_chans];
    int                   cycle_cnt = 0;

    always #50 clk = ~clk;

    load_balancer uut (
        .clk          (clk),
        .rstn         (rstn),
        .port_araddr  (port_araddr),
        .port_arvalid (port_arvalid),
        .port_arready (port_arready),
        .port_rdata   (port_rdata),
        .port_rvalid  (port_rvalid),
        .port_rready  (port_rready),
        .chan_araddr  (chan_araddr),
        .chan_arvalid (chan_arvalid),
        .chan_arready (chan_arready),
        .chan_rdata   (chan_rdata),
        .chan_rvalid  (chan_rvalid),
        .chan_rready  (chan_rready)
    );

    // channel k answers after 2+3k cycles
    for (genvar k = 0; k < num_chans; k++) begin : g_ddr
        tb_ddr_channel #(
            .LATENCY (2 + 3 * k)
        ) u_ddr (
            .clk     (clk),
            .rstn    (rstn),
            .stall   (chan_stall[k]),
            .araddr  (chan_araddr[k]),
            .arvalid (chan_arvalid[k]),
            .arready (chan_arready[k]),
            .rdata   (chan_rdata[k]),
            .rvalid  (chan_rvalid[k]),
            .rready  (chan_rready[k])
        );
    end

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic ldbal_ret_pkg::data_t expect_data(input ldbal_req_pkg::addr_t a);
        return ldbal_ret_pkg::data_t'(a) ^ 64'h5a5a_0000_0000_0000;
    endfunction

    task automatic fail_run(input string msg);
        $display("error at %0t ns: %s", $time, msg);
        $display("Test failed");
        $fatal(1);
    endtask

    always @(posedge clk) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt >= timeout_cycles) begin
            $display("run stopped: tests still busy after %0d cycles", timeout_cycles);
            $display("Test failed");
            $fatal(1);
        end
    end

    // rready levels picked at the edge and driven 10 ns later
    always @(posedge clk) begin
        stall_state = xorshift(stall_state);
        for (int p = 0; p < num_ports; p++) begin
            next_ready[p] = !hold_rready[p] && (!rand_stall || stall_state[p + 8]);
        end
        #10;
        port_rready = next_ready;
    end

    // check requester returns for order, data and stability under back-pressure
    always @(posedge clk) begin
        if (!rstn) begin
            last_valid = '0;
            last_ready = '0;
        end else begin
            for (int p = 0; p < num_ports; p++) begin
                if (last_valid[p] && !last_ready[p]) begin
                    assert (port_rvalid[p] && port_rdata[p] == last_data[p]) else
                        fail_run($sformatf("port %0d rvalid or rdata changed while stalled", p));
                end
                if (port_rvalid[p] && port_rready[p]) begin
                    assert (exp_rd[p] < exp_wr[p]) else
                        fail_run($sformatf("port %0d returned data with no read pending", p));
                    assert (port_rdata[p] == expect_data(exp_mem[p][exp_rd[p]])) else
                        fail_run($sformatf("port %0d rdata %h, expected %h", p, port_rdata[p],
                                           expect_data(exp_mem[p][exp_rd[p]])));
                    exp_rd[p] = exp_rd[p] + 1;
                end
                last_valid[p] = port_rvalid[p];
                last_ready[p] = port_rready[p];
                last_data[p]  = port_rdata[p];
            end
        end
    end

    // count channel handshakes and log them in issue order when enabled
    always @(posedge clk) begin
        for (int c = 0; c < num_chans; c++) begin
            if (rstn && chan_arvalid[c] && chan_arready[c]) begin
                chan_hs_cnt[c] = chan_hs_cnt[c] + 1;
                if (log_en && log_len < 64) begin
                    issue_log[log_len] = chan_araddr[c];
                    log_len = log_len + 1;
                end
            end
        end
    end

    task automatic apply_reset();
        rstn = 1'b0;
        repeat (5) @(posedge clk);
        #10;
        rstn = 1'b1;
        for (int p = 0; p < num_ports; p++) begin
            exp_wr[p] = 0;
            exp_rd[p] = 0;
        end
        log_len = 0;
        @(posedge clk);
        #10;
        assert (port_arready == '1 && port_rvalid == '0 && chan_rready == '1) else
            fail_run("port or channel handshake outputs wrong after reset");
        assert (chan_arvalid == '0) else
            fail_run("channel arvalid high after reset with empty queues");
    endtask

    task automatic draw_addrs(input int n);
        for (int p = 0; p < num_ports; p++) begin
            for (int i = 0; i < n; i++) begin
                rnd_state = xorshift(rnd_state);
                addr_plan[p][i][`LDBAL_ADDR_W-1:32] = rnd_state[15:0];
                rnd_state = xorshift(rnd_state);
                addr_plan[p][i][31:0] = {rnd_state[31:3], 3'b000};
            end
        end
    endtask

    // holds arvalid until the port accepts and then books the expected return
    task automatic send_read(input int p, input ldbal_req_pkg::addr_t a);
        logic done;
        done = 1'b0;
        port_araddr[p]  = a;
        port_arvalid[p] = 1'b1;
        while (!done) begin
            @(posedge clk);
            done = port_arready[p];
            #10;
        end
        port_arvalid[p]        = 1'b0;
        exp_mem[p][exp_wr[p]]  = a;
        exp_wr[p]              = exp_wr[p] + 1;
    endtask

    task automatic send_burst(input int p, input int first, input int n);
        for (int i = first; i < first + n; i++) begin
            send_read(p, addr_plan[p][i]);
        end
    endtask

    task automatic wait_drain();
        logic busy;
        busy = 1'b1;
        while (busy) begin
            @(posedge clk);
            #10;
            busy = 1'b0;
            for (int p = 0; p < num_ports; p++) begin
                if (exp_rd[p] != exp_wr[p]) begin
                    busy = 1'b1;
                end
            end
        end
    endtask

    task automatic single_read_test();
        draw_addrs(1);
        fork
            send_burst(0, 0, 1);
            send_burst(1, 0, 1);
            send_burst(2, 0, 1);
            send_burst(3, 0, 1);
        join
        wait_drain();
    endtask

    task automatic ordering_test();
        draw_addrs(8);
        rand_stall = 1'b1;
        fork
            send_burst(0, 0, 8);
            send_burst(1, 0, 8);
            send_burst(2, 0, 8);
            send_burst(3, 0, 8);
        join
        wait_drain();
        rand_stall = 1'b0;
    endtask

    task automatic port_backpressure_test();
        draw_addrs(12);
        hold_rready[2] = 1'b1;
        send_burst(2, 0, 8);
        while (!port_rvalid[2]) begin
            @(posedge clk);
            #10;
        end
        // eight reads outstanding leave no credit
        repeat (20) begin
            @(posedge clk);
            assert (!port_arready[2]) else
                fail_run("port 2 arready high with eight reads outstanding");
            #10;
        end
        hold_rready[2] = 1'b0;
        send_burst(2, 8, 4);
        wait_drain();
    endtask

    task automatic channel_stall_test();
        int base [num_chans];
        int issued;
        for (int c = 0; c < num_chans; c++) begin
            base[c] = chan_hs_cnt[c];
        end
        draw_addrs(8);
        chan_stall[0] = 1'b1;
        rand_stall    = 1'b1;
        fork
            send_burst(0, 0, 8);
            send_burst(1, 0, 8);
            send_burst(2, 0, 8);
            send_burst(3, 0, 8);
        join
        wait_drain();
        // every read goes out on a channel exactly once
        issued = 0;
        for (int c = 0; c < num_chans; c++) begin
            issued = issued + chan_hs_cnt[c] - base[c];
        end
        assert (issued == 8 * num_ports) else
            fail_run($sformatf("%0d channel reads issued, expected %0d", issued,
                               8 * num_ports));
        for (int c = 1; c < num_chans; c++) begin
            assert (chan_hs_cnt[c] > base[c]) else
                fail_run($sformatf("channel %0d carried no reads", c));
        end
        chan_stall = '0;
        rand_stall = 1'b0;
    endtask

    task automatic fair_serving_test();
        ldbal_req_pkg::addr_t predicted [8];
        int served [2];
        int taken [2];
        int pick;
        chan_stall = '1;
        apply_reset();
        draw_addrs(4);
        fork
            send_burst(0, 0, 4);
            send_burst(1, 0, 4);
        join
        // least served first with the lowest index winning a tie
        for (int p = 0; p < 2; p++) begin
            served[p] = 0;
            taken[p]  = 0;
        end
        for (int i = 0; i < 8; i++) begin
            pick = -1;
            for (int p = 0; p < 2; p++) begin
                if (taken[p] < 4 && (pick < 0 || served[p] < served[pick])) begin
                    pick = p;
                end
            end
            predicted[i] = addr_plan[pick][taken[pick]];
            taken[pick]  = taken[pick] + 1;
            served[pick] = served[pick] + 1;
        end
        log_en     = 1'b1;
        chan_stall = '0;
        wait_drain();
        log_en = 1'b0;
        assert (log_len == 8) else
            fail_run($sformatf("%0d reads issued, expected 8", log_len));
        for (int i = 0; i < 8; i++) begin
            assert (issue_log[i] == predicted[i]) else
                fail_run($sformatf("issue %0d address %h, expected %h", i, issue_log[i],
                                   predicted[i]));
        end
    endtask

    initial begin
        rstn         = 1'b0;
        port_araddr  = '0;
        port_arvalid = '0;
        port_rready  = '1;
        chan_stall   = '0;
        hold_rready  = '0;
        rand_stall   = 1'b0;
        log_en       = 1'b0;
        log_len      = 0;
        for (int c = 0; c < num_chans; c++) begin
            chan_hs_cnt[c] = 0;
        end
        apply_reset();
        single_read_test();
        ordering_test();
        port_backpressure_test();
        channel_stall_test();
        fair_serving_test();
        $display("Test completed successfully");
        $finish;
    end

endmodule

//--- load_balancer.f
+incdir+.
ldbal_req_pkg.sv
ldbal_ret_pkg.sv
sync_fifo.sv
request_queue.sv
channel_tracker.sv
issue_control.sv
reorder_buffer.sv
load_balancer.sv
tb_ddr_channel.sv
tb_load_balancer.sv

//--- Bender.yml
package:
  name: load_balancer

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - ldbal_req_pkg.sv
      - ldbal_ret_pkg.sv
      - sync_fifo.sv
      - request_queue.sv
      - channel_tracker.sv
      - issue_control.sv
      - reorder_buffer.sv
      - load_balancer.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_ddr_channel.sv
      - tb_load_balancer.sv
